// ==== flist.f ====
logic/videoPkg.sv
logic/scenePixelGen.sv
logic/videoSyncGen.sv
logic/videoDualClkFifo.sv
logic/backlightPwm.sv
logic/videoTxUnit.sv
tests/videoTxUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the videoTxUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module videoTxUnitTb -f flist.f --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
else
	echo "Pass message not found in sim.log"
	exit 1
fi

// ==== tests/videoTxUnitTb.sv ====
/* Video transmit unit testbench */

`timescale 1ns/1ps
`default_nettype none

module videoTxUnitTb;

	// Small 8x4 panel timing
	localparam int lpHDisplay   = 8;
	localparam int lpHSyncStart = 10;
	localparam int lpHSyncEnd   = 12;
	localparam int lpHSyncMax   = 15;
	localparam int lpVDisplay   = 4;
	localparam int lpVSyncStart = 5;
	localparam int lpVSyncEnd   = 6;
	localparam int lpVSyncMax   = 7;
	localparam int lpFramePos   = (lpHSyncMax + 1) * (lpVSyncMax + 1);
	localparam int lpActivePix  = lpHDisplay * lpVDisplay;
	// videoClk is half the sysClk rate
	localparam int lpFrameCycles = 2 * lpFramePos;
	// About 25 frames of tests, 40 allowed plus slack
	localparam int lpTimeoutCycles = 40 * lpFrameCycles + 1000;
	localparam int lpFadeStep   = 3;

	logic                     sysClk;
	logic                     videoClk;
	logic                     rstN;
	videoPkg::displayTiming_t timing;
	videoPkg::sceneCtrl_t     scene;
	logic [7:0]               blDutyRatio;
	videoPkg::tftOut_t        tft;
	logic                     tftDclk;
	logic                     tftBackLight;
	logic                     sceneAlphaMax;
	logic                     sceneAlphaMin;
	logic                     underrun;
	logic                     frameEnd;

	int          errCount = 0;
	int          checkCnt = 0;
	int          cycleCnt = 0;
	int unsigned seedVal;

	videoTxUnit #(
		.pFifoDepth (32),
		.pPwmWidth  (8)
	) i_dut (
		.sysClk        (sysClk),
		.videoClk      (videoClk),
		.rstN          (rstN),
		.timing        (timing),
		.scene         (scene),
		.blDutyRatio   (blDutyRatio),
		.tft           (tft),
		.tftDclk       (tftDclk),
		.tftBackLight  (tftBackLight),
		.sceneAlphaMax (sceneAlphaMax),
		.sceneAlphaMin (sceneAlphaMin),
		.underrun      (underrun),
		.frameEnd      (frameEnd)
	);

	// ----------------------------------------
	// Clocks and run limit
	// ----------------------------------------
	always #10 sysClk = ~sysClk;
	always #20 videoClk = ~videoClk;

	always @(posedge sysClk)
	begin
		cycleCnt++;
		if (cycleCnt >= lpTimeoutCycles)
		begin
			$display("Run stopped after %0d sysClk cycles, a wait never ended", cycleCnt);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic checkRgb(input videoPkg::rgb_t got, input videoPkg::rgb_t exp,
		input string what);
		checkCnt++;
		if (got !== exp)
		begin
			errCount++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		checkCnt++;
		if (got !== exp)
		begin
			errCount++;
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkCount(input int got, input int exp, input string what);
		checkCnt++;
		if (got != exp)
		begin
			errCount++;
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Expected panel color, each channel times alpha over 16
	function automatic videoPkg::rgb_t scaledColor(input videoPkg::color_t c, input int a);
		int r;
		int g;
		int b;
		r = (int'(c[11:8]) * a) / 16;
		g = (int'(c[7:4]) * a) / 16;
		b = (int'(c[3:0]) * a) / 16;
		return {r[3:0], g[3:0], b[3:0]};
	endfunction

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic waitFrameEnd();
		@(negedge videoClk);
		while (!frameEnd)
			@(negedge videoClk);
	endtask

	task automatic waitAlphaFlag(input logic wantMax, input logic level);
		@(negedge sysClk);
		while ((wantMax ? sceneAlphaMax : sceneAlphaMin) !== level)
			@(negedge sysClk);
	endtask

	// One frame of active pixels after the FIFO has drained old data
	task automatic checkFramePixels(input videoPkg::rgb_t expRgb, input string what);
		int pixCnt;
		pixCnt = 0;
		waitFrameEnd();
		waitFrameEnd();
		repeat (lpFramePos)
		begin
			@(negedge videoClk);
			if (tft.de)
			begin
				pixCnt++;
				checkRgb(tft.rgb, expRgb, what);
			end
		end
		checkCount(pixCnt, lpActivePix, "active pixels in frame");
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic resetTest();
		rstN = 1'b0;
		repeat (10)
			@(negedge sysClk);
		// Still in reset here
		checkFlag(tft.de, 1'b0, "tft.de in reset");
		checkFlag(tft.hSync, 1'b1, "tft.hSync in reset");
		checkFlag(tft.vSync, 1'b1, "tft.vSync in reset");
		checkRgb(tft.rgb, '0, "tft.rgb in reset");
		checkFlag(frameEnd, 1'b0, "frameEnd in reset");
		checkFlag(underrun, 1'b0, "underrun in reset");
		checkFlag(tftBackLight, 1'b0, "backlight in reset");
		checkFlag(sceneAlphaMin, 1'b1, "sceneAlphaMin in reset");
		checkFlag(sceneAlphaMax, 1'b0, "sceneAlphaMax in reset");
		rstN = 1'b1;
	endtask

	task automatic syncTimingTest();
		int deCnt;
		int vLowCnt;
		int frameCnt;
		int hRun;
		int hPulses;
		deCnt    = 0;
		vLowCnt  = 0;
		frameCnt = 0;
		hRun     = 0;
		hPulses  = 0;
		// First frame is blank prefill
		waitFrameEnd();
		repeat (2 * lpFramePos)
		begin
			@(negedge videoClk);
			if (tft.de)
				deCnt++;
			if (!tft.vSync)
				vLowCnt++;
			if (frameEnd)
				frameCnt++;
			if (!tft.hSync)
				hRun++;
			else if (hRun != 0)
			begin
				checkCount(hRun, lpHSyncEnd - lpHSyncStart, "hSync pulse width");
				hPulses++;
				hRun = 0;
			end
		end
		checkCount(deCnt, 2 * lpActivePix, "de cycles in two frames");
		checkCount(vLowCnt, 2 * (lpVSyncEnd - lpVSyncStart) * (lpHSyncMax + 1),
			"vSync low cycles in two frames");
		checkCount(hPulses, 2 * (lpVSyncMax + 1), "hSync pulses in two frames");
		checkCount(frameCnt, 2, "frameEnd pulses in two frames");
	endtask

	// Pixel clock follows videoClk, sampled mid-phase on sysClk
	task automatic pixelClockTest();
		logic expDclk;
		expDclk = 1'b0;
		@(negedge videoClk);
		repeat (8)
		begin
			@(posedge sysClk);
			checkFlag(tftDclk, expDclk, "tftDclk level");
			expDclk = ~expDclk;
		end
	endtask

	task automatic fadeUpTest();
		videoPkg::color_t color;
		color = videoPkg::color_t'($urandom);
		@(negedge sysClk);
		scene.color       = color;
		scene.frameTiming = 7'(lpFadeStep);
		scene.addEn       = 1'b1;
		scene.subEn       = 1'b0;
		waitAlphaFlag(1'b1, 1'b1);
		checkFramePixels(scaledColor(color, 15), "faded-in pixel");
	endtask

	task automatic fadeDownTest();
		@(negedge sysClk);
		scene.addEn = 1'b0;
		scene.subEn = 1'b1;
		waitAlphaFlag(1'b0, 1'b1);
		checkFlag(sceneAlphaMax, 1'b0, "sceneAlphaMax after fade down");
		checkFramePixels('0, "faded-out pixel");
	endtask

	task automatic sceneResetTest();
		@(negedge sysClk);
		scene.subEn = 1'b0;
		scene.addEn = 1'b1;
		// Let alpha climb off zero
		waitAlphaFlag(1'b0, 1'b0);
		scene.rst = 1'b1;
		@(negedge sysClk);
		scene.rst = 1'b0;
		checkFlag(sceneAlphaMin, 1'b1, "sceneAlphaMin after scene reset");
		scene.addEn = 1'b0;
	endtask

	task automatic backlightTest(input logic [7:0] duty);
		int highCnt;
		highCnt = 0;
		@(negedge sysClk);
		blDutyRatio = duty;
		// Two periods so the new ratio is latched
		repeat (2 * 256 + 2)
			@(negedge sysClk);
		repeat (256)
		begin
			@(negedge sysClk);
			if (tftBackLight)
				highCnt++;
		end
		checkCount(highCnt, int'(duty), "backlight high cycles");
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		seedVal     = $urandom(32'hdeea_d891);
		sysClk      = 1'b0;
		videoClk    = 1'b0;
		rstN        = 1'b0;
		scene       = '0;
		blDutyRatio = '0;
		timing.hDisplay   = 12'(lpHDisplay);
		timing.hSyncStart = 12'(lpHSyncStart);
		timing.hSyncEnd   = 12'(lpHSyncEnd);
		timing.hSyncMax   = 12'(lpHSyncMax);
		timing.vDisplay   = 12'(lpVDisplay);
		timing.vSyncStart = 12'(lpVSyncStart);
		timing.vSyncEnd   = 12'(lpVSyncEnd);
		timing.vSyncMax   = 12'(lpVSyncMax);

		resetTest();
		syncTimingTest();
		pixelClockTest();
		fadeUpTest();
		fadeDownTest();
		sceneResetTest();
		backlightTest(8'd0);
		backlightTest(8'd255);
		backlightTest(8'($urandom));
		// Sticky flag covers the whole run
		checkFlag(underrun, 1'b0, "underrun at end of run");

		$display("Checks: %0d, errors: %0d", checkCnt, errCount);
		if (errCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/videoTxUnit.sv ====
/* Video transmit unit */

`timescale 1ns/1ps
`default_nettype none

module videoTxUnit #(
	parameter int pFifoDepth = 32,
	parameter int pPwmWidth  = 8
)(
	input  wire                        sysClk,
	input  wire                        videoClk,
	input  wire                        rstN,
	input  wire videoPkg::displayTiming_t timing,
	input  wire videoPkg::sceneCtrl_t  scene,
	input  wire [pPwmWidth-1:0]        blDutyRatio,
	output videoPkg::tftOut_t          tft,
	output logic                       tftDclk,
	output logic                       tftBackLight,
	output logic                       sceneAlphaMax,
	output logic                       sceneAlphaMin,
	output logic                       underrun,
	output logic                       frameEnd
);

	videoPkg::rgb_t pixWData;
	logic           pixWEn;
	logic           fifoFull;
	videoPkg::rgb_t fifoRData;
	logic           fifoEmpty;
	logic           syncHSync;
	logic           syncVSync;
	logic           syncDe;
	// Alignment with the registered FIFO read data
	logic           hSyncQ;
	logic           vSyncQ;
	logic           deQ;
	logic           popValidQ;

	// ----------------------------------------
	// sysClk side
	// ----------------------------------------
	scenePixelGen scenePixelGen (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.scene    (scene),
		.full     (fifoFull),
		.wData    (pixWData),
		.wEn      (pixWEn),
		.alphaMax (sceneAlphaMax),
		.alphaMin (sceneAlphaMin)
	);

	backlightPwm #(
		.pWidth (pPwmWidth)
	) backlightPwm (
		.clk  (sysClk),
		.rstN (rstN),
		.duty (blDutyRatio),
		.pwm  (tftBackLight)
	);

	// Clock crossing, popped by data enable
	videoDualClkFifo #(
		.pDepth (pFifoDepth)
	) videoDualClkFifo (
		.wClk  (sysClk),
		.rClk  (videoClk),
		.rstN  (rstN),
		.wData (pixWData),
		.wEn   (pixWEn),
		.full  (fifoFull),
		.rData (fifoRData),
		.rEn   (syncDe),
		.empty (fifoEmpty)
	);

	// ----------------------------------------
	// videoClk side
	// ----------------------------------------
	videoSyncGen videoSyncGen (
		.videoClk (videoClk),
		.rstN     (rstN),
		.timing   (timing),
		.hSync    (syncHSync),
		.vSync    (syncVSync),
		.de       (syncDe),
		.frameEnd (frameEnd)
	);

	always_ff @(posedge videoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hSyncQ    <= 1'b1;
			vSyncQ    <= 1'b1;
			deQ       <= 1'b0;
			popValidQ <= 1'b0;
			underrun  <= 1'b0;
		end
		else
		begin
			hSyncQ    <= syncHSync;
			vSyncQ    <= syncVSync;
			deQ       <= syncDe;
			popValidQ <= syncDe & ~fifoEmpty;
			// Sticky until reset
			if (syncDe && fifoEmpty)
				underrun <= 1'b1;
		end
	end

	// Black on a failed pop
	assign tft = '{
		rgb:   popValidQ ? fifoRData : '0,
		hSync: hSyncQ,
		vSync: vSyncQ,
		de:    deQ
	};

	// Pixel clock straight from the video clock
	assign tftDclk = videoClk;

endmodule

`default_nettype wire

// ==== logic/backlightPwm.sv ====
/* Backlight PWM */

`timescale 1ns/1ps
`default_nettype none

module backlightPwm #(
	parameter int pWidth = 8
)(
	input  wire              clk,
	input  wire              rstN,
	input  wire [pWidth-1:0] duty,
	output logic             pwm
);

	logic [pWidth-1:0] cnt;
	// Held for a whole period
	logic [pWidth-1:0] dutyLatch;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			cnt       <= '0;
			dutyLatch <= '0;
			pwm       <= 1'b0;
		end
		else
		begin
			cnt <= cnt + 1'b1;
			// New ratio takes effect from count 0
			if (cnt == '1)
				dutyLatch <= duty;
			// High for the first duty counts
			pwm <= (cnt < dutyLatch);
		end
	end

endmodule

`default_nettype wire

// ==== logic/videoDualClkFifo.sv ====
/* Dual clock pixel FIFO */

`timescale 1ns/1ps
`default_nettype none

module videoDualClkFifo #(
	parameter int pDepth = 32
)(
	input  wire                  wClk,
	input  wire                  rClk,
	input  wire                  rstN,
	input  wire videoPkg::rgb_t  wData,
	input  wire                  wEn,
	output logic                 full,
	output videoPkg::rgb_t       rData,
	input  wire                  rEn,
	output logic                 empty
);

	// Power of two depth, at least 4
	localparam int lpAdrsWidth = $clog2(pDepth);
	localparam int lpPtrWidth  = lpAdrsWidth + 1;

	videoPkg::rgb_t        mem [pDepth];
	logic [lpPtrWidth-1:0] wPtrBin, wPtrGray, wPtrBinNext, wPtrGrayNext;
	logic [lpPtrWidth-1:0] rPtrBin, rPtrGray, rPtrBinNext, rPtrGrayNext;
	// Read pointer seen from wClk
	logic [lpPtrWidth-1:0] rGraySync1, rGraySync2;
	// Write pointer seen from rClk
	logic [lpPtrWidth-1:0] wGraySync1, wGraySync2;
	logic                  wPush;
	logic                  rPop;

	assign wPush = wEn & ~full;
	assign rPop  = rEn & ~empty;

	// ----------------------------------------
	// Write domain
	// ----------------------------------------
	assign wPtrBinNext  = wPtrBin + lpPtrWidth'(wPush);
	assign wPtrGrayNext = (wPtrBinNext >> 1) ^ wPtrBinNext;

	always_ff @(posedge wClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wPtrBin    <= '0;
			wPtrGray   <= '0;
			rGraySync1 <= '0;
			rGraySync2 <= '0;
			full       <= 1'b0;
		end
		else
		begin
			wPtrBin    <= wPtrBinNext;
			wPtrGray   <= wPtrGrayNext;
			rGraySync1 <= rPtrGray;
			rGraySync2 <= rGraySync1;
			// Full when the top two Gray bits differ and the rest match
			full       <= (wPtrGrayNext == (rGraySync2 ^ {2'b11, {(lpAdrsWidth-1){1'b0}}}));
		end
	end

	always_ff @(posedge wClk)
	begin
		if (wPush)
			mem[wPtrBin[lpAdrsWidth-1:0]] <= wData;
	end

	// ----------------------------------------
	// Read domain
	// ----------------------------------------
	assign rPtrBinNext  = rPtrBin + lpPtrWidth'(rPop);
	assign rPtrGrayNext = (rPtrBinNext >> 1) ^ rPtrBinNext;

	always_ff @(posedge rClk or negedge rstN)
	begin
		if (!rstN)
		begin
			rPtrBin    <= '0;
			rPtrGray   <= '0;
			wGraySync1 <= '0;
			wGraySync2 <= '0;
			empty      <= 1'b1;
		end
		else
		begin
			rPtrBin    <= rPtrBinNext;
			rPtrGray   <= rPtrGrayNext;
			wGraySync1 <= wPtrGray;
			wGraySync2 <= wGraySync1;
			empty      <= (rPtrGrayNext == wGraySync2);
		end
	end

	// Valid the cycle after the pop
	always_ff @(posedge rClk)
	begin
		if (rPop)
			rData <= mem[rPtrBin[lpAdrsWidth-1:0]];
	end

	// Producer must honour full
	noWriteWhenFull: assert property (@(posedge wClk) disable iff (!rstN) wEn |-> !full)
		else $error("FIFO write while full");
	wPtrKnown: assert property (@(posedge wClk) disable iff (!rstN)
		!$isunknown({wPtrGray, rGraySync2}))
		else $error("FIFO write side pointer unknown");
	rPtrKnown: assert property (@(posedge rClk) disable iff (!rstN)
		!$isunknown({rPtrGray, wGraySync2}))
		else $error("FIFO read side pointer unknown");

endmodule

`default_nettype wire

// ==== logic/videoSyncGen.sv ====
/* Display sync generator */

`timescale 1ns/1ps
`default_nettype none

module videoSyncGen (
	input  wire                        videoClk,
	input  wire                        rstN,
	input  wire videoPkg::displayTiming_t timing,
	output logic                       hSync,
	output logic                       vSync,
	output logic                       de,
	output logic                       frameEnd
);

	videoPkg::hPos_t hCount;
	videoPkg::vPos_t vCount;
	logic            lastH;
	logic            lastV;
	// First frame after reset stays blank so the FIFO prefills
	logic            frameLive;

	assign lastH = (hCount == timing.hSyncMax);
	assign lastV = (vCount == timing.vSyncMax);

	// ----------------------------------------
	// Position counters
	// ----------------------------------------
	always_ff @(posedge videoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (lastH)
		begin
			hCount <= '0;
			// Line wrap, frame wrap
			if (lastV)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
		end
		else
		begin
			hCount <= hCount + 1'b1;
		end
	end

	// Armed by the first frame end
	always_ff @(posedge videoClk or negedge rstN)
	begin
		if (!rstN)
			frameLive <= 1'b0;
		else if (frameEnd)
			frameLive <= 1'b1;
	end

	// ----------------------------------------
	// Decode
	// ----------------------------------------

	// Active low syncs
	assign hSync    = ~((hCount >= timing.hSyncStart) && (hCount < timing.hSyncEnd));
	assign vSync    = ~((vCount >= timing.vSyncStart) && (vCount < timing.vSyncEnd));
	// Active area
	assign de       = frameLive && (hCount < timing.hDisplay) && (vCount < timing.vDisplay);
	// Last position of the frame
	assign frameEnd = lastH && lastV;

	// Sync pulse must close before the line wraps
	hSyncInLine: assert property (@(posedge videoClk) disable iff (!rstN)
		timing.hSyncEnd <= timing.hSyncMax)
		else $error("hSyncEnd beyond hSyncMax");

endmodule

`default_nettype wire

// ==== logic/scenePixelGen.sv ====
/* Scene fill pixel generator */

`timescale 1ns/1ps
`default_nettype none

module scenePixelGen (
	input  wire                    sysClk,
	input  wire                    rstN,
	input  wire videoPkg::sceneCtrl_t scene,
	input  wire                    full,
	output videoPkg::rgb_t         wData,
	output logic                   wEn,
	output logic                   alphaMax,
	output logic                   alphaMin
);

	videoPkg::alpha_t     alpha;
	videoPkg::frameStep_t stepCnt;
	logic                 genEn;
	logic                 stepDone;

	// Channel times alpha, upper nibble of the product
	function automatic logic [3:0] scaleChannel(input logic [3:0] ch, input videoPkg::alpha_t a);
		logic [7:0] prod;
		prod = ch * a;
		return prod[7:4];
	endfunction

	// ----------------------------------------
	// Write side
	// ----------------------------------------

	// Starts one cycle after reset release
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
			genEn <= 1'b0;
		else
			genEn <= 1'b1;
	end

	// One pixel per cycle, stalled by back-pressure
	assign wEn      = genEn & ~full;
	// Last write of a fade step
	assign stepDone = wEn && (stepCnt == scene.frameTiming);

	// ----------------------------------------
	// Fade control
	// ----------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			stepCnt <= '0;
			alpha   <= '0;
		end
		else if (scene.rst)
		begin
			// Scene reset wins over any fade
			stepCnt <= '0;
			alpha   <= '0;
		end
		else if (stepDone)
		begin
			stepCnt <= '0;
			// Saturating step, add has priority
			if (scene.addEn && (alpha != 4'hf))
				alpha <= alpha + 1'b1;
			else if (scene.subEn && (alpha != 4'h0))
				alpha <= alpha - 1'b1;
		end
		else if (wEn)
		begin
			stepCnt <= stepCnt + 1'b1;
		end
	end

	// Scene alpha nibble is not used, fade alpha replaces it
	assign wData = {
		scaleChannel(scene.color[11:8], alpha),
		scaleChannel(scene.color[7:4], alpha),
		scaleChannel(scene.color[3:0], alpha)
	};

	// Fade end flags
	assign alphaMax = (alpha == 4'hf);
	assign alphaMin = (alpha == 4'h0);

endmodule

`default_nettype wire

// ==== logic/videoPkg.sv ====
/* Video transmit types */

`default_nettype none

package videoPkg;

	// Counter widths cover a full line or frame including blanking
	typedef logic [11:0] hPos_t;
	typedef logic [11:0] vPos_t;

	// ARGB4444, alpha in the top nibble then R, G, B
	typedef logic [15:0] color_t;
	// RGB444 as shown on the panel and stored in the FIFO
	typedef logic [11:0] rgb_t;
	// Fade level 0 to 15
	typedef logic [3:0] alpha_t;
	// Pixels per fade step minus one
	typedef logic [6:0] frameStep_t;

	// Run-time display timing
	typedef struct packed {
		hPos_t hDisplay;
		vPos_t vDisplay;
		hPos_t hSyncStart;
		hPos_t hSyncEnd;
		hPos_t hSyncMax;
		vPos_t vSyncStart;
		vPos_t vSyncEnd;
		vPos_t vSyncMax;
	} displayTiming_t;

	// Scene fill and fade control
	typedef struct packed {
		color_t     color;
		frameStep_t frameTiming;
		logic       addEn;
		logic       subEn;
		logic       rst;
	} sceneCtrl_t;

	// TFT pin group
	typedef struct packed {
		rgb_t rgb;
		logic hSync;
		logic vSync;
		logic de;
	} tftOut_t;

endpackage

`default_nettype wire
